// ==== src/afifo_config.svh ====
`ifndef AFIFO_CONFIG_SVH
`define AFIFO_CONFIG_SVH

// Width of one data word in bits.
`define AFIFO_DATA_WIDTH 8

// Number of entries in the storage array.
`define AFIFO_DEPTH 16

// Address bits for the storage array; pointers carry one extra wrap bit.
`define AFIFO_ADDR_WIDTH 4

// Almost-full is raised when the write-side level reaches this value.
`define AFIFO_AFULL 14

// Almost-empty is raised when the read-side level is at or below this value.
`define AFIFO_AEMPTY 2

`endif

// ==== src/afifo_pkg.sv ====
`include "afifo_config.svh"

package afifo_pkg;

  typedef logic [`AFIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`AFIFO_ADDR_WIDTH-1:0] addr_t;

  // Binary and Gray pointers share this type; the top bit is the wrap bit.
  typedef logic [`AFIFO_ADDR_WIDTH:0]   ptr_t;

  // Occupancy from 0 up to and including the depth.
  typedef logic [`AFIFO_ADDR_WIDTH:0]   level_t;

  typedef struct packed {
    logic  en;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic   full;
    logic   afull;
    level_t level;
  } wr_status_t;

  typedef struct packed {
    logic   empty;
    logic   aempty;
    level_t level;
  } rd_status_t;

endpackage

// ==== src/dualport_ram_async.sv ====
`timescale 1ns/1ps

`include "afifo_config.svh"

module dualport_ram_async (
  input  logic              wr_clk,
  input  logic              wr_en,
  input  afifo_pkg::addr_t  wr_addr,
  input  afifo_pkg::data_t  wr_data,
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  input  afifo_pkg::addr_t  rd_addr,
  output afifo_pkg::data_t  rd_data
);

  afifo_pkg::data_t mem [0:`AFIFO_DEPTH-1];

  // Write port, owned entirely by the write clock.
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port. The word stays put until the next accepted read.
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== src/gray_ptr_sync.sv ====
`timescale 1ns/1ps

module gray_ptr_sync (
  input  logic             clk,
  input  logic             rst_n,
  input  afifo_pkg::ptr_t  gray_in,
  output afifo_pkg::ptr_t  bin_out
);

  afifo_pkg::ptr_t gray_meta;
  afifo_pkg::ptr_t gray_sync;

  // Only one bit of a Gray pointer changes per step, so a sampled value is
  // either the old or the new pointer, never a mix.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in; // First stage may go metastable.
      gray_sync <= gray_meta;
    end
  end

  // Gray to binary, folding from the top bit down.
  always_comb begin
    bin_out[$bits(afifo_pkg::ptr_t)-1] = gray_sync[$bits(afifo_pkg::ptr_t)-1];
    for (int i = $bits(afifo_pkg::ptr_t) - 2; i >= 0; i--) begin
      bin_out[i] = bin_out[i+1] ^ gray_sync[i];
    end
  end

endmodule

// ==== src/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps

`include "afifo_config.svh"

module fifo_wr_ctrl (
  input  logic                   wr_clk,
  input  logic                   wr_rst_n,
  input  afifo_pkg::wr_req_t     wr_req,
  input  afifo_pkg::ptr_t        rd_ptr_sync,
  output logic                   wr_accept,
  output afifo_pkg::addr_t       wr_addr,
  output afifo_pkg::ptr_t        wr_gray,
  output afifo_pkg::wr_status_t  wr_status
);

  afifo_pkg::ptr_t       wr_ptr;
  afifo_pkg::ptr_t       wr_ptr_nxt;
  afifo_pkg::ptr_t       wr_gray_nxt;
  afifo_pkg::level_t     level_nxt;
  afifo_pkg::wr_status_t wr_status_nxt;

  // A write while full is simply dropped.
  assign wr_accept = wr_req.en & ~wr_status.full;

  // The RAM is written at the current pointer on the accepting edge.
  assign wr_addr = afifo_pkg::addr_t'(wr_ptr);

  assign wr_ptr_nxt  = wr_ptr + afifo_pkg::ptr_t'(wr_accept);
  assign wr_gray_nxt = wr_ptr_nxt ^ (wr_ptr_nxt >> 1);

  // The synchronized read pointer lags, so this level can only overstate
  // the true fill. That keeps full on the safe side.
  assign level_nxt = afifo_pkg::level_t'(wr_ptr_nxt - rd_ptr_sync);

  always_comb begin
    wr_status_nxt.full  = (level_nxt == afifo_pkg::level_t'(`AFIFO_DEPTH));
    wr_status_nxt.afull = (level_nxt >= afifo_pkg::level_t'(`AFIFO_AFULL));
    wr_status_nxt.level = level_nxt;
  end

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
    end
  end

  // Registered Gray copy, so the synchronizer never sees a decode glitch.
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_gray <= '0;
    end else begin
      wr_gray <= wr_gray_nxt;
    end
  end

  // Status reflects a write accepted on this same edge.
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_status <= '0;
    end else begin
      wr_status <= wr_status_nxt;
    end
  end

endmodule

// ==== src/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps

`include "afifo_config.svh"

module fifo_rd_ctrl (
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   rd_en,
  input  afifo_pkg::ptr_t        wr_ptr_sync,
  output logic                   rd_accept,
  output afifo_pkg::addr_t       rd_addr,
  output afifo_pkg::ptr_t        rd_gray,
  output afifo_pkg::rd_status_t  rd_status
);

  afifo_pkg::ptr_t       rd_ptr;
  afifo_pkg::ptr_t       rd_ptr_nxt;
  afifo_pkg::ptr_t       rd_gray_nxt;
  afifo_pkg::level_t     level_nxt;
  afifo_pkg::rd_status_t rd_status_nxt;

  // A read while empty is ignored.
  assign rd_accept = rd_en & ~rd_status.empty;

  // The RAM reads the entry being accepted, at the current pointer.
  assign rd_addr = afifo_pkg::addr_t'(rd_ptr);

  assign rd_ptr_nxt  = rd_ptr + afifo_pkg::ptr_t'(rd_accept);
  assign rd_gray_nxt = rd_ptr_nxt ^ (rd_ptr_nxt >> 1);

  // The write pointer arrives late, so the level here can only understate
  // the fill, and empty errs toward staying high.
  assign level_nxt = afifo_pkg::level_t'(wr_ptr_sync - rd_ptr_nxt);

  always_comb begin
    rd_status_nxt.empty  = (level_nxt == '0);
    rd_status_nxt.aempty = (level_nxt <= afifo_pkg::level_t'(`AFIFO_AEMPTY));
    rd_status_nxt.level  = level_nxt;
  end

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_gray <= '0;
    end else begin
      rd_gray <= rd_gray_nxt;
    end
  end

  // An empty FIFO is also almost empty, hence both flags set out of reset.
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
      rd_status.level  <= '0;
    end else begin
      rd_status <= rd_status_nxt;
    end
  end

endmodule

// ==== src/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
  input  logic                   wr_clk,
  input  logic                   wr_rst_n,
  input  afifo_pkg::wr_req_t     wr_req,
  output afifo_pkg::wr_status_t  wr_status,
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   rd_en,
  output afifo_pkg::data_t       rd_data,
  output afifo_pkg::rd_status_t  rd_status
);

  logic             wr_accept;
  afifo_pkg::addr_t wr_addr;
  afifo_pkg::ptr_t  wr_gray;
  afifo_pkg::ptr_t  wr_ptr_sync;

  logic             rd_accept;
  afifo_pkg::addr_t rd_addr;
  afifo_pkg::ptr_t  rd_gray;
  afifo_pkg::ptr_t  rd_ptr_sync;

  fifo_wr_ctrl wr_ctrl_inst (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_req      (wr_req),
    .rd_ptr_sync (rd_ptr_sync),
    .wr_accept   (wr_accept),
    .wr_addr     (wr_addr),
    .wr_gray     (wr_gray),
    .wr_status   (wr_status)
  );

  fifo_rd_ctrl rd_ctrl_inst (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_sync (wr_ptr_sync),
    .rd_accept   (rd_accept),
    .rd_addr     (rd_addr),
    .rd_gray     (rd_gray),
    .rd_status   (rd_status)
  );

  // Write pointer into the read domain.
  gray_ptr_sync wr_to_rd_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_sync)
  );

  // Read pointer into the write domain.
  gray_ptr_sync rd_to_wr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_sync)
  );

  dualport_ram_async ram_inst (
    .wr_clk   (wr_clk),
    .wr_en    (wr_accept),
    .wr_addr  (wr_addr),
    .wr_data  (wr_req.data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_accept),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// ==== verification/async_fifo_tb_checks.svh ====
`ifndef ASYNC_FIFO_TB_CHECKS_SVH
`define ASYNC_FIFO_TB_CHECKS_SVH

task automatic check_data(input string name, input afifo_pkg::data_t exp,
                          input afifo_pkg::data_t act);
  if (act !== exp) begin
    $display("FAIL %s: expected 0x%h, actual 0x%h", name, exp, act);
    error_count++;
  end
endtask

task automatic check_level(input string name, input afifo_pkg::level_t exp,
                           input afifo_pkg::level_t act);
  if (act !== exp) begin
    $display("FAIL %s: expected 0x%h, actual 0x%h", name, exp, act);
    error_count++;
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("FAIL %s: expected 0x%h, actual 0x%h", name, exp, act);
    error_count++;
  end
endtask

// The oldest accepted write is the next word out.
function automatic afifo_pkg::data_t expected_read_data();
  return model_q[0];
endfunction

function automatic afifo_pkg::level_t model_level();
  return afifo_pkg::level_t'(model_q.size());
endfunction

function automatic logic expected_afull(input afifo_pkg::level_t lvl);
  return (lvl >= `AFIFO_AFULL);
endfunction

function automatic logic expected_aempty(input afifo_pkg::level_t lvl);
  return (lvl <= `AFIFO_AEMPTY);
endfunction

`endif

// ==== verification/async_fifo_tb.sv ====
`timescale 1ns/1ps

`include "afifo_config.svh"

module async_fifo_tb;

  localparam int WR_PERIOD = 4;
  localparam int RD_PERIOD = 6;
  localparam int EXTRA_WRITES = 4;
  localparam int RAND_CYCLES = 300;
  localparam int DRAIN_LIMIT = 20 * `AFIFO_DEPTH;
  // Fill, drain, threshold writes and drain, random writes and reads.
  localparam int PLANNED_XFERS = (`AFIFO_DEPTH + EXTRA_WRITES) + `AFIFO_DEPTH
                               + 2 * (`AFIFO_DEPTH - 1) + 2 * RAND_CYCLES;
  localparam int TIMEOUT_CYCLES = 20 * PLANNED_XFERS;

  logic                  wr_clk;
  logic                  wr_rst_n;
  afifo_pkg::wr_req_t    wr_req;
  afifo_pkg::wr_status_t wr_status;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  afifo_pkg::data_t      rd_data;
  afifo_pkg::rd_status_t rd_status;

  afifo_pkg::data_t model_q[$];
  integer           seed;
  int               error_count;
  int               tests_passed;
  int               tests_failed;
  int               reads_done;
  int               cycle_count;
  logic             traffic_done;

  `include "async_fifo_tb_checks.svh"

  async_fifo async_fifo_inst (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_req    (wr_req),
    .wr_status (wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_status (rd_status)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  end

  // Acceptance follows the full flag as it stood before the edge.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_req.en && !wr_status.full) begin
      model_q.push_back(wr_req.data);
    end
  end

  initial begin : read_compare
    afifo_pkg::data_t exp_word;
    forever begin
      @(posedge rd_clk);
      if (rd_rst_n && rd_en && !rd_status.empty) begin
        reads_done++;
        if (model_q.size() == 0) begin
          $display("ERROR: the FIFO accepted a read while no written word was pending");
          error_count++;
        end else begin
          exp_word = expected_read_data();
          void'(model_q.pop_front());
          @(negedge rd_clk); // The registered word is stable by mid-cycle.
          check_data("rd_data", exp_word, rd_data);
        end
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge wr_clk);
      cycle_count++;
    end
    $display("ERROR: the run did not finish within %0d wr_clk cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  task automatic write_words(input int count);
    integer rand_word;
    @(posedge wr_clk);
    #1;
    for (int i = 0; i < count; i++) begin
      rand_word = $random(seed);
      wr_req.en = 1'b1;
      wr_req.data = afifo_pkg::data_t'(rand_word);
      @(posedge wr_clk);
      #1;
    end
    wr_req.en = 1'b0;
  endtask

  task automatic read_words(input int count);
    int target;
    @(posedge rd_clk);
    #1;
    target = reads_done + count;
    rd_en = 1'b1;
    while (reads_done < target) begin
      @(posedge rd_clk);
      #1;
    end
    rd_en = 1'b0;
    @(negedge rd_clk); // The compare process checks the last word here.
    #1;
  endtask

  task automatic drain_model();
    int waited;
    waited = 0;
    @(posedge rd_clk);
    #1;
    rd_en = 1'b1;
    while (model_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge rd_clk);
      #1;
      waited++;
    end
    rd_en = 1'b0;
    @(negedge rd_clk); // The compare process checks the last word here.
    #1;
    if (model_q.size() != 0) begin
      $display("ERROR: %0d accepted writes never came out of the FIFO", model_q.size());
      error_count++;
    end
  endtask

  task automatic quiet_rd(input int cycles);
    repeat (cycles) @(posedge rd_clk);
    #1;
  endtask

  task automatic random_traffic();
    integer rand_word;
    traffic_done = 1'b0;
    fork
      begin
        @(posedge wr_clk);
        #1;
        repeat (RAND_CYCLES) begin
          rand_word = $random(seed);
          wr_req.en = rand_word[0];
          wr_req.data = afifo_pkg::data_t'(rand_word >> 8);
          @(posedge wr_clk);
          #1;
        end
        wr_req.en = 1'b0;
        traffic_done = 1'b1;
      end
      begin
        @(posedge rd_clk);
        #1;
        while (!traffic_done) begin
          rand_word = $random(seed);
          rd_en = rand_word[0];
          @(posedge rd_clk);
          #1;
        end
        rd_en = 1'b0;
      end
    join
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic check_thresholds();
    check_flag("wr_status.afull", expected_afull(model_level()), wr_status.afull);
    check_flag("rd_status.aempty", expected_aempty(model_level()), rd_status.aempty);
    check_level("wr_status.level", model_level(), wr_status.level);
    check_level("rd_status.level", model_level(), rd_status.level);
  endtask

  initial begin : main_sequence
    int errors_before;
    int levels[5];
    levels = '{1, 2, 3, 14, 15};
    seed = 32'hea6d4440;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    reads_done = 0;
    traffic_done = 1'b0;
    wr_req = '0;
    rd_en = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    fork
      begin
        repeat (10) @(posedge wr_clk);
        #1;
        wr_rst_n = 1'b1;
      end
      begin
        repeat (10) @(posedge rd_clk);
        #1;
        rd_rst_n = 1'b1;
      end
    join

    errors_before = error_count;
    check_flag("wr_status.full", 1'b0, wr_status.full);
    check_flag("wr_status.afull", 1'b0, wr_status.afull);
    check_level("wr_status.level", '0, wr_status.level);
    check_flag("rd_status.empty", 1'b1, rd_status.empty);
    check_flag("rd_status.aempty", 1'b1, rd_status.aempty);
    check_level("rd_status.level", '0, rd_status.level);
    check_data("rd_data", '0, rd_data);
    end_test("reset_values", errors_before);

    errors_before = error_count;
    write_words(`AFIFO_DEPTH + EXTRA_WRITES); // The last few land while full.
    check_flag("wr_status.full", 1'b1, wr_status.full);
    check_level("wr_status.level", afifo_pkg::level_t'(`AFIFO_DEPTH), wr_status.level);
    quiet_rd(10);
    check_level("rd_status.level", afifo_pkg::level_t'(`AFIFO_DEPTH), rd_status.level);
    end_test("fill_to_full", errors_before);

    errors_before = error_count;
    read_words(`AFIFO_DEPTH);
    check_flag("rd_status.empty", 1'b1, rd_status.empty);
    end_test("drain", errors_before);

    errors_before = error_count;
    quiet_rd(10);
    foreach (levels[i]) begin
      write_words(levels[i] - model_q.size());
      quiet_rd(10);
      check_thresholds();
    end
    drain_model();
    end_test("thresholds", errors_before);

    errors_before = error_count;
    random_traffic();
    drain_model();
    quiet_rd(10);
    check_flag("rd_status.empty", 1'b1, rd_status.empty);
    check_level("rd_status.level", '0, rd_status.level);
    check_level("wr_status.level", '0, wr_status.level);
    end_test("random_traffic", errors_before);

    $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+src
+incdir+verification
src/afifo_pkg.sv
src/dualport_ram_async.sv
src/gray_ptr_sync.sv
src/fifo_wr_ctrl.sv
src/fifo_rd_ctrl.sv
src/async_fifo.sv
verification/async_fifo_tb.sv
